/* include/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// First fetch address after reset
`define CPU_RESET_VECTOR 32'h0000_1000

// r0 reads zero, r15 is P
`define CPU_NUM_REGS 16

// Top nibble that halts the core
`define CPU_ILLEGAL_NIBBLE 4'hF

`endif

/* logic/alu_exec.sv */
`timescale 1ns/1ps

module alu_exec (
    input  logic               i_reset_n,   // Clock
    input  logic               i_reset,
    input  logic               i_start,
    input  cpu_pkg::cpu_word_t  i_x,
    input  cpu_pkg::cpu_word_t  i_y,
    input  logic [11:0]        i_imm,
    input  logic               i_type,
    input  cpu_pkg::cpu_op_e    i_op,
    output cpu_pkg::cpu_word_t  o_rhs
);

    cpu_pkg::cpu_word_t imm_sext;
    cpu_pkg::cpu_word_t opnd_o;
    cpu_pkg::cpu_word_t addend_a;
    cpu_pkg::cpu_word_t op_res;
    logic [4:0]        shamt;

    assign imm_sext = {{20{i_imm[11]}}, i_imm};

    // Type bit swaps Y and the immediate
    assign opnd_o   = i_type ? imm_sext : i_y;
    assign addend_a = i_type ? i_y : imm_sext;

    assign shamt = opnd_o[4:0];

    always_comb begin
        case (i_op)
            cpu_pkg::OP_OR:   op_res = i_x | opnd_o;
            cpu_pkg::OP_AND:  op_res = i_x & opnd_o;
            cpu_pkg::OP_ADD:  op_res = i_x + opnd_o;
            cpu_pkg::OP_MUL:  op_res = i_x * opnd_o;  // Low 32 bits
            cpu_pkg::OP_SHL:  op_res = i_x << shamt;
            cpu_pkg::OP_LE:   op_res = {31'd0, $signed(i_x) <= $signed(opnd_o)};
            cpu_pkg::OP_EQ:   op_res = {31'd0, i_x == opnd_o};
            cpu_pkg::OP_NOR:  op_res = ~(i_x | opnd_o);
            cpu_pkg::OP_NAND: op_res = ~(i_x & opnd_o);
            cpu_pkg::OP_XOR:  op_res = i_x ^ opnd_o;
            cpu_pkg::OP_SUB:  op_res = i_x + (~opnd_o + 32'd1);
            cpu_pkg::OP_XORN: op_res = i_x ^ ~opnd_o;
            cpu_pkg::OP_SHR:  op_res = i_x >> shamt;   // Logical
            cpu_pkg::OP_GT:   op_res = {31'd0, $signed(i_x) > $signed(opnd_o)};
            cpu_pkg::OP_NE:   op_res = {31'd0, i_x != opnd_o};
            default:          op_res = '0;             // Reserved, core halts
        endcase
    end

    // Result is valid the cycle after i_start
    always_ff @(posedge i_reset_n) begin
        if (i_reset)
            o_rhs <= '0;
        else if (i_start)
            o_rhs <= op_res + addend_a;
    end

endmodule

/* logic/cpu_core.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_core (
    input  logic               i_reset_n,   // Clock
    input  logic               i_reset,
    output logic               o_insn_req,
    output cpu_pkg::cpu_word_t  o_insn_addr,
    input  logic               i_insn_ack,
    input  cpu_pkg::cpu_word_t  i_insn_data,
    output logic               o_mem_req,
    output logic               o_mem_we,
    output cpu_pkg::cpu_word_t  o_mem_addr,
    output cpu_pkg::cpu_word_t  o_mem_wdata,
    input  logic               i_mem_ack,
    input  cpu_pkg::cpu_word_t  i_mem_rdata,
    output logic               o_halt
);

    cpu_pkg::cpu_state_e    state;
    cpu_pkg::cpu_word_t     pc;
    cpu_pkg::cpu_word_t     pc_next;
    cpu_pkg::cpu_word_t     insn_q;
    cpu_pkg::cpu_word_t     load_q;
    logic                  insn_req_q;

    cpu_pkg::cpu_reg_idx_t  idx_z;
    cpu_pkg::cpu_reg_idx_t  idx_x;
    cpu_pkg::cpu_reg_idx_t  idx_y;
    cpu_pkg::cpu_reg_idx_t  rd_idx_x;
    logic [11:0]           imm;
    cpu_pkg::cpu_op_e       op;
    cpu_pkg::cpu_deref_e    deref;
    logic                  insn_type;
    logic                  nop;
    logic                  illegal;

    cpu_pkg::cpu_word_t     rd_val_x;
    cpu_pkg::cpu_word_t     rd_val_y;
    cpu_pkg::cpu_word_t     rhs;
    cpu_pkg::cpu_word_t     wr_val;
    logic                  writes_z;
    logic                  wr_en;

    assign pc_next = pc + 32'd1;

    // Kinds 00 and 01 target Z, stores do not
    assign writes_z = ~nop && (deref == cpu_pkg::DR_REG || deref == cpu_pkg::DR_LOAD);
    assign wr_val   = (deref == cpu_pkg::DR_LOAD) ? load_q : rhs;
    assign wr_en    = (state == cpu_pkg::ST_WRITE) && writes_z && idx_z != 4'd0;

    // X port doubles as the Z read outside of execute
    assign rd_idx_x = (state == cpu_pkg::ST_EXEC) ? idx_x : idx_z;

    assign o_insn_req  = insn_req_q;
    assign o_insn_addr = pc;
    assign o_halt      = (state == cpu_pkg::ST_HALT);

    // Data request fields held while in ST_MEM
    assign o_mem_req   = (state == cpu_pkg::ST_MEM);
    assign o_mem_we    = o_mem_req && deref[1];
    assign o_mem_addr  = (deref == cpu_pkg::DR_STORE_RHS) ? rd_val_x : rhs;
    assign o_mem_wdata = (deref == cpu_pkg::DR_STORE_Z) ? rd_val_x : rhs;

    always_ff @(posedge i_reset_n) begin
        if (i_reset) begin
            state      <= cpu_pkg::ST_FETCH;
            pc         <= `CPU_RESET_VECTOR;
            insn_req_q <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::ST_FETCH: begin
                    if (!insn_req_q && !i_insn_ack) begin
                        insn_req_q <= 1'b1;
                    end else if (insn_req_q && i_insn_ack) begin
                        insn_req_q <= 1'b0;
                        state      <= cpu_pkg::ST_FETCH_REL;
                    end
                end
                cpu_pkg::ST_FETCH_REL: begin
                    if (!i_insn_ack)
                        state <= illegal ? cpu_pkg::ST_HALT : cpu_pkg::ST_EXEC;
                end
                cpu_pkg::ST_EXEC: begin
                    // No-ops skip the data bus
                    if (nop || deref == cpu_pkg::DR_REG)
                        state <= cpu_pkg::ST_WRITE;
                    else
                        state <= cpu_pkg::ST_MEM;
                end
                cpu_pkg::ST_MEM: begin
                    if (i_mem_ack)
                        state <= cpu_pkg::ST_MEM_REL;
                end
                cpu_pkg::ST_MEM_REL: begin
                    if (!i_mem_ack)
                        state <= cpu_pkg::ST_WRITE;
                end
                cpu_pkg::ST_WRITE: begin
                    if (writes_z && idx_z == 4'd15)
                        pc <= wr_val;     // Jump
                    else
                        pc <= pc_next;
                    state <= cpu_pkg::ST_FETCH;
                end
                default: begin
                    state <= cpu_pkg::ST_HALT;  // Stuck until reset
                end
            endcase
        end
    end

    always_ff @(posedge i_reset_n) begin
        if (state == cpu_pkg::ST_FETCH && insn_req_q && i_insn_ack)
            insn_q <= i_insn_data;
        if (state == cpu_pkg::ST_MEM && i_mem_ack)
            load_q <= i_mem_rdata;       // Read data valid with ack
    end

    reg_file u_regs (
        .i_reset_n  (i_reset_n),
        .i_reset    (i_reset),
        .i_rd_idx_x (rd_idx_x),
        .i_rd_idx_y (idx_y),
        .o_rd_val_x (rd_val_x),
        .o_rd_val_y (rd_val_y),
        .i_wr_en    (wr_en),
        .i_wr_idx   (idx_z),
        .i_wr_val   (wr_val),
        .i_pc_next  (pc_next)
    );

    insn_decode u_decode (
        .i_insn    (insn_q),
        .o_idx_z   (idx_z),
        .o_idx_x   (idx_x),
        .o_idx_y   (idx_y),
        .o_imm     (imm),
        .o_op      (op),
        .o_deref   (deref),
        .o_type    (insn_type),
        .o_nop     (nop),
        .o_illegal (illegal)
    );

    alu_exec u_alu (
        .i_reset_n (i_reset_n),
        .i_reset   (i_reset),
        .i_start   (state == cpu_pkg::ST_EXEC),
        .i_x       (rd_val_x),
        .i_y       (rd_val_y),
        .i_imm     (imm),
        .i_type    (insn_type),
        .i_op      (op),
        .o_rhs     (rhs)
    );

    // Req and its fields hold until the ack
    a_insn_req_hold : assert property (
        @(posedge i_reset_n) disable iff (i_reset)
        o_insn_req && !i_insn_ack |=> o_insn_req && $stable(o_insn_addr)
    );

    a_mem_req_hold : assert property (
        @(posedge i_reset_n) disable iff (i_reset)
        o_mem_req && !i_mem_ack |=> o_mem_req && $stable(o_mem_we)
            && $stable(o_mem_addr) && $stable(o_mem_wdata)
    );

    // Halted core stays halted and silent
    a_halt_sticky : assert property (
        @(posedge i_reset_n) disable iff (i_reset)
        o_halt |=> o_halt && !o_insn_req && !o_mem_req
    );

endmodule

/* logic/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] cpu_word_t;   // Data word or address
    typedef logic [3:0]  cpu_reg_idx_t;

    // Right-hand side ops, encoding order matters
    typedef enum logic [3:0] {
        OP_OR   = 4'h0,
        OP_AND  = 4'h1,
        OP_ADD  = 4'h2,
        OP_MUL  = 4'h3,
        OP_RSVD = 4'h4,  // Halts the core
        OP_SHL  = 4'h5,
        OP_LE   = 4'h6,
        OP_EQ   = 4'h7,
        OP_NOR  = 4'h8,
        OP_NAND = 4'h9,
        OP_XOR  = 4'hA,
        OP_SUB  = 4'hB,
        OP_XORN = 4'hC,
        OP_SHR  = 4'hD,
        OP_GT   = 4'hE,
        OP_NE   = 4'hF
    } cpu_op_e;

    typedef enum logic [1:0] {
        DR_REG       = 2'b00,  // Z <- rhs
        DR_LOAD      = 2'b01,  // Z <- [rhs]
        DR_STORE_RHS = 2'b10,  // [Z] <- rhs
        DR_STORE_Z   = 2'b11   // [rhs] <- Z
    } cpu_deref_e;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_FETCH_REL,
        ST_EXEC,
        ST_MEM,
        ST_MEM_REL,
        ST_WRITE,
        ST_HALT
    } cpu_state_e;

endpackage

/* logic/insn_decode.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module insn_decode (
    input  cpu_pkg::cpu_word_t     i_insn,
    output cpu_pkg::cpu_reg_idx_t  o_idx_z,
    output cpu_pkg::cpu_reg_idx_t  o_idx_x,
    output cpu_pkg::cpu_reg_idx_t  o_idx_y,
    output logic [11:0]           o_imm,
    output cpu_pkg::cpu_op_e       o_op,
    output cpu_pkg::cpu_deref_e    o_deref,
    output logic                  o_type,
    output logic                  o_nop,
    output logic                  o_illegal
);

    logic is_normal;
    logic top_illegal;
    logic rsvd_op;

    // Field extraction, layout is fixed
    assign o_type  = i_insn[30];
    assign o_deref = cpu_pkg::cpu_deref_e'(i_insn[29:28]);
    assign o_idx_z = i_insn[27:24];
    assign o_idx_x = i_insn[23:20];
    assign o_idx_y = i_insn[19:16];
    assign o_op    = cpu_pkg::cpu_op_e'(i_insn[15:12]);
    assign o_imm   = i_insn[11:0];

    assign is_normal   = ~i_insn[31];
    assign top_illegal = (i_insn[31:28] == `CPU_ILLEGAL_NIBBLE);

    // Reserved op only matters for normal instructions
    assign rsvd_op = is_normal && (o_op == cpu_pkg::OP_RSVD);

    assign o_illegal = top_illegal || rsvd_op;
    assign o_nop     = ~is_normal && ~top_illegal;  // Other top bit set words

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module reg_file (
    input  logic                 i_reset_n,   // Clock
    input  logic                 i_reset,
    input  cpu_pkg::cpu_reg_idx_t i_rd_idx_x,
    input  cpu_pkg::cpu_reg_idx_t i_rd_idx_y,
    output cpu_pkg::cpu_word_t    o_rd_val_x,
    output cpu_pkg::cpu_word_t    o_rd_val_y,
    input  logic                 i_wr_en,
    input  cpu_pkg::cpu_reg_idx_t i_wr_idx,
    input  cpu_pkg::cpu_word_t    i_wr_val,
    input  cpu_pkg::cpu_word_t    i_pc_next
);

    localparam int LAST_GPR = `CPU_NUM_REGS - 2;  // r14

    // Only r1 to r14 are stored here
    cpu_pkg::cpu_word_t regs [1:LAST_GPR];

    always_ff @(posedge i_reset_n) begin
        if (i_reset) begin
            for (int i = 1; i <= LAST_GPR; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && i_wr_idx != 4'd0 && i_wr_idx != 4'd15) begin
            regs[i_wr_idx] <= i_wr_val;
        end
    end

    always_comb begin
        if (i_rd_idx_x == 4'd0)
            o_rd_val_x = '0;
        else if (i_rd_idx_x == 4'd15)
            o_rd_val_x = i_pc_next;       // P reads as current plus one
        else
            o_rd_val_x = regs[i_rd_idx_x];
    end

    always_comb begin
        if (i_rd_idx_y == 4'd0)
            o_rd_val_y = '0;
        else if (i_rd_idx_y == 4'd15)
            o_rd_val_y = i_pc_next;
        else
            o_rd_val_y = regs[i_rd_idx_y];
    end

    // Core must filter r0 targets before they reach the write port
    a_no_r0_write : assert property (
        @(posedge i_reset_n) disable iff (i_reset)
        i_wr_en |-> i_wr_idx != 4'd0
    );

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tb.f --top-module tb_cpu -o tb_cpu_sim
./obj_dir/tb_cpu_sim

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic o_reset_n   // Clock
);

    initial o_reset_n = 1'b0;

    always #(PERIOD_NS / 2) o_reset_n = ~o_reset_n;

endmodule

/* sim/tb_cpu.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_cpu;

    localparam int NUM_INSNS       = 400;
    localparam int CYCLES_PER_INSN = 20;
    localparam int CLK_PERIOD_NS   = 4;
    localparam int WATCHDOG_NS     = NUM_INSNS * CYCLES_PER_INSN * CLK_PERIOD_NS + 2000;
    localparam logic [31:0] LOAD_MASK = 32'hA5A5_0F0F;

    logic               reset_n;   // Clock
    logic               reset;
    logic               insn_req;
    cpu_pkg::cpu_word_t insn_addr;
    logic               insn_ack;
    cpu_pkg::cpu_word_t insn_data;
    logic               mem_req;
    logic               mem_we;
    cpu_pkg::cpu_word_t mem_addr;
    cpu_pkg::cpu_word_t mem_wdata;
    logic               mem_ack;
    cpu_pkg::cpu_word_t mem_rdata;
    logic               halt;

    cpu_pkg::cpu_word_t lfsr_state;
    cpu_pkg::cpu_word_t model_regs [`CPU_NUM_REGS];
    cpu_pkg::cpu_word_t model_pc;

    tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) u_clock (.o_reset_n(reset_n));

    cpu_core i_dut (
        .i_reset_n   (reset_n),
        .i_reset     (reset),
        .o_insn_req  (insn_req),
        .o_insn_addr (insn_addr),
        .i_insn_ack  (insn_ack),
        .i_insn_data (insn_data),
        .o_mem_req   (mem_req),
        .o_mem_we    (mem_we),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .i_mem_ack   (mem_ack),
        .i_mem_rdata (mem_rdata),
        .o_halt      (halt)
    );

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input cpu_pkg::cpu_word_t exp,
                              input cpu_pkg::cpu_word_t act);
        if (act !== exp)
            report_fail($sformatf("** Error: %s expected 32'h%08h actual 32'h%08h",
                                  name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_fail($sformatf("** Error: %s expected %b actual %b", name, exp, act));
    endtask

    // Outputs settle and inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge reset_n);
        #1;
    endtask

    // Right-shift Galois LFSR
    function automatic cpu_pkg::cpu_word_t rand_bits(input int n);
        cpu_pkg::cpu_word_t val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return val;
    endfunction

    // Mostly normal words and a few no-ops
    function automatic cpu_pkg::cpu_word_t make_insn();
        cpu_pkg::cpu_word_t sel;
        cpu_pkg::cpu_word_t body;
        cpu_pkg::cpu_word_t hdr;
        cpu_pkg::cpu_word_t small_imm;
        cpu_pkg::cpu_word_t insn;
        sel  = rand_bits(3);
        body = rand_bits(28);
        hdr  = rand_bits(3);
        if (sel[2:0] == 3'd0) begin
            insn = {1'b1, hdr[2:0], body[27:0]};
            if (insn[31:28] == `CPU_ILLEGAL_NIBBLE)
                insn[31:28] = 4'hE;
        end else begin
            insn = {1'b0, hdr[2:0], body[27:0]};
            if (insn[15:12] == 4'h4)
                insn[15:12] = 4'h2;   // No reserved op in the stream
            small_imm = rand_bits(6);
            if (small_imm[5])
                insn[11:0] = {{7{small_imm[4]}}, small_imm[4:0]};
        end
        return insn;
    endfunction

    function automatic cpu_pkg::cpu_word_t model_read(input cpu_pkg::cpu_reg_idx_t idx);
        if (idx == 4'd0)
            return '0;
        if (idx == 4'd15)
            return model_pc + 32'd1;   // P reads as next address
        return model_regs[idx];
    endfunction

    task automatic model_write(input cpu_pkg::cpu_reg_idx_t idx, input cpu_pkg::cpu_word_t val);
        if (idx == 4'd15) begin
            model_pc = val;   // Jump
        end else begin
            if (idx != 4'd0)
                model_regs[idx] = val;
            model_pc = model_pc + 32'd1;
        end
    endtask

    // (X op O) + A
    function automatic cpu_pkg::cpu_word_t model_rhs(input cpu_pkg::cpu_word_t word);
        cpu_pkg::cpu_word_t x;
        cpu_pkg::cpu_word_t imm;
        cpu_pkg::cpu_word_t o;
        cpu_pkg::cpu_word_t a;
        cpu_pkg::cpu_word_t r;
        x   = model_read(word[23:20]);
        imm = {{20{word[11]}}, word[11:0]};
        o   = word[30] ? imm : model_read(word[19:16]);
        a   = word[30] ? model_read(word[19:16]) : imm;
        case (cpu_pkg::cpu_op_e'(word[15:12]))
            cpu_pkg::OP_OR:   r = x | o;
            cpu_pkg::OP_AND:  r = x & o;
            cpu_pkg::OP_ADD:  r = x + o;
            cpu_pkg::OP_MUL:  r = x * o;
            cpu_pkg::OP_SHL:  r = x << o[4:0];
            cpu_pkg::OP_LE:   r = ($signed(x) <= $signed(o)) ? 32'd1 : 32'd0;
            cpu_pkg::OP_EQ:   r = (x == o) ? 32'd1 : 32'd0;
            cpu_pkg::OP_NOR:  r = ~(x | o);
            cpu_pkg::OP_NAND: r = ~(x & o);
            cpu_pkg::OP_XOR:  r = x ^ o;
            cpu_pkg::OP_SUB:  r = x - o;
            cpu_pkg::OP_XORN: r = x ^ ~o;
            cpu_pkg::OP_SHR:  r = x >> o[4:0];
            cpu_pkg::OP_GT:   r = ($signed(x) > $signed(o)) ? 32'd1 : 32'd0;
            cpu_pkg::OP_NE:   r = (x != o) ? 32'd1 : 32'd0;
            default:          r = '0;
        endcase
        return r + a;
    endfunction

    task automatic apply_reset();
        reset = 1'b1;
        repeat (3) next_cycle();
        reset = 1'b0;
        for (int i = 0; i < `CPU_NUM_REGS; i++)
            model_regs[i] = '0;
        model_pc = `CPU_RESET_VECTOR;
    endtask

    // Fetch responder with a random ack delay
    task automatic serve_fetch(input cpu_pkg::cpu_word_t word, input string name);
        cpu_pkg::cpu_word_t held_addr;
        cpu_pkg::cpu_word_t delay;
        while (!insn_req) begin
            if (mem_req)
                report_fail($sformatf("%s: data request seen while waiting for a fetch", name));
            next_cycle();
        end
        check_flag({name, " halt"}, 1'b0, halt);
        check_word({name, " fetch addr"}, model_pc, insn_addr);
        held_addr = insn_addr;
        delay     = rand_bits(2);
        repeat (delay[1:0]) begin
            next_cycle();
            check_flag({name, " fetch req held"}, 1'b1, insn_req);
            check_word({name, " fetch addr held"}, held_addr, insn_addr);
        end
        insn_ack  = 1'b1;
        insn_data = word;
        next_cycle();
        while (insn_req) begin
            check_word({name, " fetch addr held"}, held_addr, insn_addr);
            next_cycle();
        end
        insn_ack  = 1'b0;
        insn_data = ~word;   // Not valid with ack low
    endtask

    // Data responder where loads return address ^ LOAD_MASK
    task automatic serve_mem(input string name, input logic exp_we,
                             input cpu_pkg::cpu_word_t exp_addr,
                             input cpu_pkg::cpu_word_t exp_wdata);
        cpu_pkg::cpu_word_t delay;
        while (!mem_req) begin
            if (insn_req)
                report_fail($sformatf("%s: fetch request came before the data access", name));
            next_cycle();
        end
        delay = rand_bits(2);
        for (int i = 0; i <= int'(delay[1:0]); i++) begin
            if (i > 0) begin
                next_cycle();
                check_flag({name, " mem req held"}, 1'b1, mem_req);
            end
            check_flag({name, " mem we"}, exp_we, mem_we);
            check_word({name, " mem addr"}, exp_addr, mem_addr);
            if (exp_we)
                check_word({name, " mem wdata"}, exp_wdata, mem_wdata);
        end
        mem_ack   = 1'b1;
        mem_rdata = mem_addr ^ LOAD_MASK;
        next_cycle();
        while (mem_req) begin
            check_word({name, " mem addr held"}, exp_addr, mem_addr);
            next_cycle();
        end
        mem_ack   = 1'b0;
        mem_rdata = '0;
    endtask

    task automatic run_insn(input int n);
        cpu_pkg::cpu_word_t    word;
        cpu_pkg::cpu_word_t    rhs;
        cpu_pkg::cpu_reg_idx_t z;
        string                 name;
        name = $sformatf("insn %0d", n);
        word = make_insn();
        serve_fetch(word, name);
        if (word[31]) begin
            model_pc = model_pc + 32'd1;   // No-op
        end else begin
            rhs = model_rhs(word);
            z   = word[27:24];
            case (cpu_pkg::cpu_deref_e'(word[29:28]))
                cpu_pkg::DR_REG: model_write(z, rhs);
                cpu_pkg::DR_LOAD: begin
                    serve_mem(name, 1'b0, rhs, '0);
                    model_write(z, rhs ^ LOAD_MASK);
                end
                cpu_pkg::DR_STORE_RHS: begin
                    serve_mem(name, 1'b1, model_read(z), rhs);
                    model_pc = model_pc + 32'd1;
                end
                default: begin
                    serve_mem(name, 1'b1, rhs, model_read(z));
                    model_pc = model_pc + 32'd1;
                end
            endcase
        end
    endtask

    task automatic wait_for_halt(input string name);
        int cycles;
        cycles = 0;
        while (!halt && cycles < 8) begin
            next_cycle();
            cycles++;
        end
        check_flag({name, " halt raised"}, 1'b1, halt);
    endtask

    // Halted core stays silent on both buses
    task automatic check_quiet(input string name);
        repeat (50) begin
            next_cycle();
            check_flag({name, " halt held"}, 1'b1, halt);
            check_flag({name, " fetch after halt"}, 1'b0, insn_req);
            check_flag({name, " data request after halt"}, 1'b0, mem_req);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_fail("Timeout: the core did not finish the test sequence in time");
    end

    initial begin
        reset      = 1'b1;
        insn_ack   = 1'b0;
        insn_data  = '0;
        mem_ack    = 1'b0;
        mem_rdata  = '0;
        lfsr_state = 32'h67ce58a0;
        apply_reset();
        for (int n = 0; n < NUM_INSNS; n++)
            run_insn(n);
        serve_fetch(32'hF000_0000, "illegal word");
        wait_for_halt("illegal word");
        check_quiet("illegal word");

        // Second pass ends on the reserved op
        apply_reset();
        check_flag("halt after reset", 1'b0, halt);
        for (int n = 0; n < 4; n++)
            run_insn(NUM_INSNS + n);
        serve_fetch(32'h0123_4005, "reserved op");
        wait_for_halt("reserved op");
        check_quiet("reserved op");
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
logic/cpu_pkg.sv
logic/reg_file.sv
logic/insn_decode.sv
logic/alu_exec.sv
logic/cpu_core.sv
sim/tb_clock.sv
sim/tb_cpu.sv
